// File: src/reflet_pkg.sv
package reflet_pkg;

    // Datapath and interrupt sizes
    localparam int word_size = 16;
    localparam int irq_count = 4;
    localparam int stack_depth = 4;

    // Derived widths
    localparam int slot_width = $clog2(irq_count);
    localparam int stack_index_width = $clog2(stack_depth);
    localparam int stack_ptr_width = stack_index_width + 1; // Counts 0 to stack_depth

    typedef logic [word_size-1:0] word_t;

    // 0 to 3 while a routine runs, 0 is the most urgent
    typedef logic [2:0] level_t;

    localparam level_t level_normal = 3'd4; // Normal context, no routine running

    // Instruction encodings
    localparam logic [5:0] opp_setint = 6'h0B; // Low two bits select the slot
    localparam logic [7:0] inst_retint = 8'h30;

    // Register file index of the program counter
    localparam logic [3:0] pc_id = 4'hF;

    // What the CPU shows the interrupt unit each cycle
    typedef struct packed {
        logic [7:0] instruction;
        word_t      working_register;
        word_t      program_counter;
    } cpu_bus_t;

    // What the interrupt unit hands back to the CPU
    typedef struct packed {
        word_t      value;    // Data to write back
        logic [3:0] dest_reg; // Register that receives value
        word_t      routine;  // Jump target on interrupt entry
    } irq_result_t;

endpackage

// File: src/reflet_stack.sv
`timescale 1ns/1ps

module reflet_stack #(
    parameter type entry_t = logic [7:0]
) (
    input  logic   clk,
    input  logic   reset,
    input  logic   enable,
    input  logic   push,
    input  logic   pop,
    input  entry_t data_in,
    output entry_t top
);

    entry_t entries [reflet_pkg::stack_depth];

    logic [reflet_pkg::stack_ptr_width-1:0] count; // Number of stored entries
    logic [reflet_pkg::stack_ptr_width-1:0] below;
    logic [reflet_pkg::stack_index_width-1:0] write_index;
    logic [reflet_pkg::stack_index_width-1:0] top_index;
    logic empty;
    logic full;

    assign empty = (count == '0);
    assign full = (int'(count) == reflet_pkg::stack_depth);

    assign below = count - 1'b1;
    assign write_index = count[reflet_pkg::stack_index_width-1:0];
    assign top_index = below[reflet_pkg::stack_index_width-1:0];

    // Pointer moves once per accepted push or pop
    always_ff @(posedge clk)
    begin
        if (!reset)
            count <= '0;
        else if (enable)
        begin
            if (push && !full)
                count <= count + 1'b1;
            else if (pop && !empty)
                count <= below;
        end
    end

    always_ff @(posedge clk)
    begin
        if (enable && push && !full)
            entries[write_index] <= data_in;
    end

    assign top = empty ? '0 : entries[top_index]; // Zero when nothing is saved

    // Caller contract
    assert property (@(posedge clk) disable iff (!reset) enable |-> !(push && pop))
        else $error("stack push and pop in the same cycle");
    assert property (@(posedge clk) disable iff (!reset) (enable && push) |-> !full)
        else $error("stack push while full");
    assert property (@(posedge clk) disable iff (!reset) (enable && pop) |-> !empty)
        else $error("stack pop while empty");

endmodule

// File: src/reflet_irq_latch.sv
`timescale 1ns/1ps

module reflet_irq_latch (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           enable,
    input  logic [reflet_pkg::irq_count-1:0] interrupt_request,
    input  logic [reflet_pkg::irq_count-1:0] int_mask,
    input  logic                           cpu_update,
    output reflet_pkg::level_t             target_level
);

    logic [reflet_pkg::irq_count-1:0] masked;
    logic [reflet_pkg::irq_count-1:0] pending;

    assign masked = interrupt_request & int_mask;

    // Short pulses stay pending until the CPU has looked at them
    always_ff @(posedge clk)
    begin
        if (!reset)
            pending <= '0;
        else if (enable)
        begin
            if (cpu_update)
                pending <= masked; // Fresh snapshot at each instruction
            else
                pending <= pending | masked;
        end
    end

    // Lowest pending index wins
    always_comb
    begin
        target_level = reflet_pkg::level_normal;
        for (int i = reflet_pkg::irq_count - 1; i >= 0; i--)
        begin
            if (pending[i])
                target_level = reflet_pkg::level_t'(i);
        end
    end

endmodule

// File: src/reflet_irq_vectors.sv
`timescale 1ns/1ps

module reflet_irq_vectors (
    input  logic                 clk,
    input  logic                 reset,
    input  reflet_pkg::cpu_bus_t cpu,
    input  reflet_pkg::level_t   target_level,
    output reflet_pkg::word_t    routine
);

    reflet_pkg::word_t routines [reflet_pkg::irq_count];

    logic is_setint;
    logic [reflet_pkg::slot_width-1:0] write_slot;
    reflet_pkg::level_t read_index;

    assign is_setint = (cpu.instruction[7:2] == reflet_pkg::opp_setint);
    assign write_slot = cpu.instruction[reflet_pkg::slot_width-1:0];

    // setint is honored even while the unit is disabled
    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            for (int i = 0; i < reflet_pkg::irq_count; i++)
                routines[i] <= '0;
        end
        else if (is_setint)
            routines[write_slot] <= cpu.working_register;
    end

    // Normal context falls back to slot 0
    assign read_index = (target_level == reflet_pkg::level_normal) ? '0 : target_level;
    assign routine = routines[read_index[reflet_pkg::slot_width-1:0]];

    assert property (@(posedge clk) disable iff (!reset)
        int'(read_index) < reflet_pkg::irq_count)
        else $error("routine table index out of range");

endmodule

// File: src/reflet_interrupt.sv
`timescale 1ns/1ps

module reflet_interrupt (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             enable,
    input  logic [reflet_pkg::irq_count-1:0] interrupt_request, // Bit 0 is interrupt 0
    input  logic [reflet_pkg::irq_count-1:0] int_mask,
    input  reflet_pkg::cpu_bus_t             cpu,
    input  logic                             cpu_update, // One pulse per executed instruction
    output reflet_pkg::irq_result_t          result,
    output logic                             interrupt
);

    reflet_pkg::level_t level;        // Level of the running context
    reflet_pkg::level_t target_level; // Most urgent pending request
    reflet_pkg::level_t level_top;    // Level to return to
    reflet_pkg::word_t  pc_top;       // Saved program counter
    reflet_pkg::word_t  routine;

    logic is_setint;
    logic is_retint;
    logic new_int;
    logic quit_int;

    // Instruction decode
    assign is_setint = (cpu.instruction[7:2] == reflet_pkg::opp_setint);
    assign is_retint = (cpu.instruction == reflet_pkg::inst_retint);

    reflet_irq_latch i_reflet_irq_latch (
        .clk               (clk),
        .reset             (reset),
        .enable            (enable),
        .interrupt_request (interrupt_request),
        .int_mask          (int_mask),
        .cpu_update        (cpu_update),
        .target_level      (target_level)
    );

    reflet_irq_vectors i_reflet_irq_vectors (
        .clk          (clk),
        .reset        (reset),
        .cpu          (cpu),
        .target_level (target_level),
        .routine      (routine)
    );

    // Entry only preempts a less urgent context
    assign new_int = enable && cpu_update && (target_level < level);

    // Entry wins over a retint in the same instruction
    assign quit_int = enable && cpu_update && is_retint && !new_int;

    always_ff @(posedge clk)
    begin
        if (!reset)
            level <= reflet_pkg::level_normal;
        else if (enable)
        begin
            if (new_int)
                level <= target_level;
            else if (quit_int)
                level <= level_top; // Back to the interrupted context
        end
    end

    // Return address of the interrupted code
    reflet_stack #(
        .entry_t (reflet_pkg::word_t)
    ) i_pc_stack (
        .clk     (clk),
        .reset   (reset),
        .enable  (enable),
        .push    (new_int),
        .pop     (quit_int),
        .data_in (cpu.program_counter),
        .top     (pc_top)
    );

    // Level of the interrupted context
    reflet_stack #(
        .entry_t (reflet_pkg::level_t)
    ) i_level_stack (
        .clk     (clk),
        .reset   (reset),
        .enable  (enable),
        .push    (new_int),
        .pop     (quit_int),
        .data_in (level),
        .top     (level_top)
    );

    // Write-back to the CPU
    always_comb
    begin
        result = '0;
        if (is_setint)
            result.value = cpu.working_register; // Acts like a no-op write
        else if (is_retint)
        begin
            result.value = pc_top - reflet_pkg::word_t'(1);
            result.dest_reg = reflet_pkg::pc_id;
        end
        result.routine = routine;
    end

    assign interrupt = new_int;

    // Level stays within the encoded range
    assert property (@(posedge clk) disable iff (!reset)
        level <= reflet_pkg::level_normal)
        else $error("interrupt level out of range");

    // Exit always returns to a less urgent context
    assert property (@(posedge clk) disable iff (!reset)
        quit_int |=> (level > $past(level)))
        else $error("level not restored on retint");

endmodule

// File: test/reflet_interrupt_model.sv
`timescale 1ns/1ps

module reflet_interrupt_model (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             enable,
    input  logic [reflet_pkg::irq_count-1:0] interrupt_request,
    input  logic [reflet_pkg::irq_count-1:0] int_mask,
    input  reflet_pkg::cpu_bus_t             cpu,
    input  logic                             cpu_update,
    output reflet_pkg::irq_result_t          result,
    output logic                             interrupt,
    output reflet_pkg::level_t               level,
    output int                               depth // Saved contexts
);

    logic [reflet_pkg::irq_count-1:0] pending;
    reflet_pkg::word_t slots [reflet_pkg::irq_count]; // Routine addresses
    reflet_pkg::word_t saved_pc [$];
    reflet_pkg::level_t saved_level [$];
    reflet_pkg::word_t pc_top;
    reflet_pkg::level_t target;

    function automatic reflet_pkg::level_t lowest_pending(
        input logic [reflet_pkg::irq_count-1:0] bits);
        for (int i = 0; i < reflet_pkg::irq_count; i++)
        begin
            if (bits[i])
                return reflet_pkg::level_t'(i);
        end
        return reflet_pkg::level_normal;
    endfunction

    // Expected outputs for the current cycle
    always_comb
    begin
        target = lowest_pending(pending);
        interrupt = enable && cpu_update && (target < level);
        result = '0;
        if (cpu.instruction[7:2] == reflet_pkg::opp_setint)
            result.value = cpu.working_register;
        else if (cpu.instruction == reflet_pkg::inst_retint)
        begin
            result.value = pc_top - 16'd1; // Address after the saved one minus one
            result.dest_reg = reflet_pkg::pc_id;
        end
        if (target == reflet_pkg::level_normal)
            result.routine = slots[0];
        else
            result.routine = slots[target[1:0]];
    end

    always @(posedge clk)
    begin
        logic take;
        logic leave;
        take = interrupt;
        leave = enable && cpu_update && (cpu.instruction == reflet_pkg::inst_retint) && !take;
        if (!reset)
        begin
            pending = '0;
            level = reflet_pkg::level_normal;
            for (int i = 0; i < reflet_pkg::irq_count; i++)
                slots[i] = '0;
            saved_pc.delete();
            saved_level.delete();
        end
        else
        begin
            if (cpu.instruction[7:2] == reflet_pkg::opp_setint)
                slots[cpu.instruction[1:0]] = cpu.working_register; // Even when disabled
            if (enable)
            begin
                if (take)
                begin
                    saved_pc.push_back(cpu.program_counter);
                    saved_level.push_back(level);
                    level = target;
                end
                else if (leave)
                begin
                    level = saved_level.pop_back();
                    void'(saved_pc.pop_back());
                end
                if (cpu_update)
                    pending = interrupt_request & int_mask;
                else
                    pending = pending | (interrupt_request & int_mask);
            end
        end
        pc_top = (saved_pc.size() > 0) ? saved_pc[$] : '0;
        depth = saved_pc.size();
    end

endmodule

// File: test/tb_reflet_interrupt.sv
`timescale 1ns/1ps

module tb_reflet_interrupt;

    localparam int reset_cycles = 16;
    localparam int directed_cycles = 64; // Upper bound of the directed part
    localparam int random_cycles = 1800;
    localparam int margin_cycles = 120;
    localparam int timeout_cycles = reset_cycles + directed_cycles + random_cycles
        + margin_cycles;

    typedef logic [reflet_pkg::irq_count-1:0] lines_t;

    logic clk;
    logic reset;
    logic enable;
    lines_t interrupt_request;
    lines_t int_mask;
    reflet_pkg::cpu_bus_t cpu;
    logic cpu_update;
    reflet_pkg::irq_result_t result;
    logic interrupt;

    // Model outputs
    reflet_pkg::irq_result_t exp_result;
    logic exp_interrupt;
    reflet_pkg::level_t exp_level;
    int model_depth;

    string test_name = "reset";
    int cycle_count = 0;
    reflet_pkg::word_t pc_count = 16'h0100;

    reflet_interrupt i_reflet_interrupt (
        .clk               (clk),
        .reset             (reset),
        .enable            (enable),
        .interrupt_request (interrupt_request),
        .int_mask          (int_mask),
        .cpu               (cpu),
        .cpu_update        (cpu_update),
        .result            (result),
        .interrupt         (interrupt)
    );

    reflet_interrupt_model model (
        .clk               (clk),
        .reset             (reset),
        .enable            (enable),
        .interrupt_request (interrupt_request),
        .int_mask          (int_mask),
        .cpu               (cpu),
        .cpu_update        (cpu_update),
        .result            (exp_result),
        .interrupt         (exp_interrupt),
        .level             (exp_level),
        .depth             (model_depth)
    );

    always #2 clk = ~clk;

    task automatic stop_with_failure();
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles)
        begin
            $display("Timeout after %0d cycles, the stimulus never finished", cycle_count);
            stop_with_failure();
        end
    end

    task automatic check_bit(input string what, input logic expected, input logic actual);
        if (expected !== actual)
        begin
            $display("Fail %s %s: expected %b, actual %b", test_name, what, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic check_result(input string what, input reflet_pkg::irq_result_t expected,
                                input reflet_pkg::irq_result_t actual);
        if (expected !== actual)
        begin
            $display("Fail %s %s: expected %h, actual %h", test_name, what, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic check_level(input string what, input reflet_pkg::level_t expected,
                               input reflet_pkg::level_t actual);
        if (expected !== actual)
        begin
            $display("Fail %s %s: expected %0d, actual %0d", test_name, what, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic compare_outputs();
        check_bit("interrupt", exp_interrupt, interrupt);
        check_result("result", exp_result, result);
        check_level("level", exp_level, i_reflet_interrupt.level);
    endtask

    // Called just after a falling edge, checks before the next rising edge
    task automatic drive_and_check(input logic [7:0] instruction, input reflet_pkg::word_t data,
                                   input lines_t request, input lines_t mask,
                                   input logic update, input logic en);
        pc_count = pc_count + 16'd2;
        cpu.instruction = instruction;
        cpu.working_register = data;
        cpu.program_counter = pc_count;
        interrupt_request = request;
        int_mask = mask;
        cpu_update = update;
        enable = en;
        #1;
        compare_outputs();
    endtask

    task automatic apply_cycle(input logic [7:0] instruction, input reflet_pkg::word_t data,
                               input lines_t request, input lines_t mask,
                               input logic update, input logic en);
        @(negedge clk);
        drive_and_check(instruction, data, request, mask, update, en);
    endtask

    // Mostly setint, retint and no-ops
    function automatic logic [7:0] random_instruction(input int depth);
        logic [7:0] code;
        int pick;
        pick = int'($urandom % 8);
        code = 8'($urandom);
        if (pick < 2)
            code = {reflet_pkg::opp_setint, 2'($urandom)};
        else if (pick < 4 && depth > 0)
            code = reflet_pkg::inst_retint; // Only with a saved context
        else if (pick < 6 || code[7:2] == reflet_pkg::opp_setint
                 || code == reflet_pkg::inst_retint)
            code = 8'h00;
        return code;
    endfunction

    task automatic run_directed();
        test_name = "reset_state";
        repeat (4) apply_cycle(8'h00, 16'h1234, '0, 4'hF, 1'b0, 1'b1);

        test_name = "setint";
        for (int slot = 0; slot < reflet_pkg::irq_count; slot++)
            apply_cycle({reflet_pkg::opp_setint, 2'(slot)}, 16'h4000 + 16'(slot * 256),
                        '0, 4'hF, 1'b0, 1'b1);

        test_name = "masked_request";
        apply_cycle(8'h00, '0, 4'b1000, 4'b0111, 1'b0, 1'b1);
        apply_cycle(8'h00, '0, '0, 4'b0111, 1'b1, 1'b1);
        check_bit("masked request taken", 1'b0, interrupt);

        test_name = "request_pulse";
        apply_cycle(8'h00, '0, 4'b0100, 4'hF, 1'b0, 1'b1); // One-cycle pulse
        apply_cycle(8'h00, '0, '0, 4'hF, 1'b0, 1'b1);
        apply_cycle(8'h00, '0, '0, 4'hF, 1'b1, 1'b1);
        check_bit("held pulse taken", 1'b1, interrupt);

        test_name = "nesting";
        apply_cycle(8'h00, '0, 4'b0010, 4'hF, 1'b0, 1'b1);
        apply_cycle(8'h00, '0, '0, 4'hF, 1'b1, 1'b1); // Level 2 to 1
        apply_cycle(8'h00, '0, 4'b0001, 4'hF, 1'b0, 1'b1);
        apply_cycle(8'h00, '0, '0, 4'hF, 1'b1, 1'b1); // Level 1 to 0
        repeat (3) apply_cycle(reflet_pkg::inst_retint, '0, '0, 4'hF, 1'b1, 1'b1);
        apply_cycle(8'h00, '0, '0, 4'hF, 1'b0, 1'b1);
        check_level("restored level", reflet_pkg::level_normal, i_reflet_interrupt.level);

        test_name = "enable_low";
        apply_cycle(8'h00, '0, 4'b0001, 4'hF, 1'b0, 1'b1); // Pending before the drop
        apply_cycle({reflet_pkg::opp_setint, 2'd3}, 16'h7777, 4'b1000, 4'hF, 1'b1, 1'b0);
        check_bit("interrupt while disabled", 1'b0, interrupt);
        apply_cycle(8'h00, '0, '0, 4'hF, 1'b1, 1'b1);
        check_bit("request held while disabled", 1'b1, interrupt);
        apply_cycle(8'h00, '0, 4'b1000, 4'hF, 1'b0, 1'b1);
        apply_cycle(8'h00, '0, '0, 4'hF, 1'b1, 1'b1); // Slot 3 written while disabled
        apply_cycle(reflet_pkg::inst_retint, '0, '0, 4'hF, 1'b1, 1'b1);
    endtask

    task automatic run_random();
        lines_t mask;
        lines_t request;
        logic [7:0] instruction;
        logic update;
        logic en;
        mask = 4'hF;
        test_name = "random";
        for (int n = 0; n < random_cycles; n++)
        begin
            @(negedge clk);
            if (($urandom % 32) == 0)
                mask = lines_t'($urandom);
            request = (($urandom % 4) == 0) ? lines_t'($urandom) : '0;
            update = ($urandom % 3) == 0;
            en = ($urandom % 16) != 0; // Occasional enable drop
            instruction = random_instruction(model_depth);
            drive_and_check(instruction, 16'($urandom), request, mask, update, en);
        end
    endtask

    initial
    begin
        void'($urandom(32'h6b3b_c24f));
        clk = 1'b0;
        reset = 1'b0;
        enable = 1'b0;
        interrupt_request = '0;
        int_mask = '0;
        cpu = '0;
        cpu_update = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b1;
        enable = 1'b1;
        run_directed();
        run_random();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// File: reflet_irq.f
src/reflet_pkg.sv
src/reflet_stack.sv
src/reflet_irq_latch.sv
src/reflet_irq_vectors.sv
src/reflet_interrupt.sv
test/reflet_interrupt_model.sv
test/tb_reflet_interrupt.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the interrupt unit testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert --timing --timescale 1ns/1ps -Wno-fatal \
    --top-module tb_reflet_interrupt \
    -f reflet_irq.f \
    -o tb_reflet_interrupt

status=0
./obj_dir/tb_reflet_interrupt > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
    echo "Simulation failed"
    exit 1
fi
if [ "$status" -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi
echo "Simulation passed"
